// File: logic/dscg_consts.svh
// dscg oscillator constants for widths, pipeline stage counts and buffer depths
`ifndef DSCG_CONSTS_SVH
`define DSCG_CONSTS_SVH

// fixed-point operand format, one is 2**DSCG_FRAC
`define DSCG_WIDTH 32
`define DSCG_FRAC 30

// arithmetic pipeline latencies
`define DSCG_MUL_STAGES 3
`define DSCG_ADD_STAGES 1

// issue to result, first adder, multiplier, final adder
`define DSCG_LATENCY (2 * `DSCG_ADD_STAGES + `DSCG_MUL_STAGES)

// number of independent oscillator channels
`define DSCG_CHANNELS 4

// command FIFO depth, also the sender's starting credit count
`define DSCG_CMD_DEPTH 4

// result FIFO depth and the consumer's buffer size
`define DSCG_OUT_DEPTH 4
`define DSCG_OUT_CREDITS 2

`endif

// File: logic/dscg_pkg.sv
// dscg oscillator shared types for commands, issue bundles and samples
`include "dscg_consts.svh"

package dscg_pkg;

	// signed fixed point, DSCG_FRAC fraction bits
	typedef logic signed [`DSCG_WIDTH-1:0] sample_t;

	typedef logic [$clog2(`DSCG_CHANNELS)-1:0] chan_t;

	typedef enum logic [1:0]
	{
		SET_COEF  = 2'd0,
		SET_STATE = 2'd1,
		STEP      = 2'd2
	} cmd_op_e;

	// SET_COEF takes a as c, SET_STATE takes a as s1 and b as s2
	typedef struct packed
	{
		cmd_op_e op;
		chan_t   chan;
		sample_t a;
		sample_t b;
	} cmd_t;

	// one channel's coefficient and state, sent to execute
	typedef struct packed
	{
		chan_t   chan;
		sample_t c;
		sample_t s1;
		sample_t s2;
	} issue_t;

	// rides beside the arithmetic to mark valid results
	typedef struct packed
	{
		logic  valid;
		chan_t chan;
	} tag_t;

	typedef struct packed
	{
		chan_t   chan;
		sample_t s1;
		sample_t s2;
	} sample_pair_t;

endpackage

// File: logic/credit_fifo.sv
// circular FIFO that pulses a credit back to the sender on every pop
module credit_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic clock,
	input  logic rst,
	input  logic push,
	input  T     push_data,
	input  logic pop,
	output T     pop_data,
	output logic empty,
	output logic credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic push_ok;
	logic pop_ok;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign push_ok = push && !full;
	assign pop_ok = pop && !empty;

	// show-ahead read of the head entry
	assign pop_data = mem[rd_ptr];
	assign credit = pop_ok;

	always_ff @(posedge clock)
	begin
		if (push_ok)
		begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_ok)
			begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok)
			begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
		end
	end

endmodule

// File: logic/delay_line.sv
// fixed-depth register chain that delays any payload type
module delay_line #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 1
) (
	input  logic clock,
	input  logic rst,
	input  T     in_data,
	output T     out_data
);

	T stages [DEPTH];

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				stages[i] <= '0;
			end
		end
		else
		begin
			stages[0] <= in_data;
			for (int i = 1; i < DEPTH; i++)
			begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign out_data = stages[DEPTH-1];

endmodule

// File: logic/fxp_mul_pipe.sv
// pipelined signed fixed-point multiplier, floor rescale by the fraction width
`include "dscg_consts.svh"

module fxp_mul_pipe (
	input  logic              clock,
	input  dscg_pkg::sample_t a,
	input  dscg_pkg::sample_t b,
	output dscg_pkg::sample_t p
);

	localparam int TAIL = `DSCG_MUL_STAGES - 2;

	dscg_pkg::sample_t a_q;
	dscg_pkg::sample_t b_q;
	logic signed [2*`DSCG_WIDTH-1:0] prod_q;
	dscg_pkg::sample_t tail_q [TAIL];

	always_ff @(posedge clock)
	begin
		// stage one holds the operands, stage two the full product
		a_q <= a;
		b_q <= b;
		prod_q <= a_q * b_q;
		// arithmetic shift right then keep the low word, same as a slice
		tail_q[0] <= prod_q[`DSCG_FRAC +: `DSCG_WIDTH];
		for (int i = 1; i < TAIL; i++)
		begin
			tail_q[i] <= tail_q[i-1];
		end
	end

	assign p = tail_q[TAIL-1];

endmodule

// File: logic/dscg_decode.sv
// command decoder with per-channel coefficient and state, hazard stall and issue
`include "dscg_consts.svh"

module dscg_decode (
	input  logic                   clock,
	input  logic                   rst,
	input  dscg_pkg::cmd_t         cmd,
	input  logic                   cmd_empty,
	input  dscg_pkg::sample_pair_t res,
	input  logic                   res_valid,
	input  logic                   slot_free,
	output logic                   cmd_pop,
	output dscg_pkg::issue_t       issue,
	output logic                   issue_valid
);

	localparam int SLOT_W = $clog2(`DSCG_OUT_DEPTH + 1);

	dscg_pkg::sample_t c_q [`DSCG_CHANNELS];
	dscg_pkg::sample_t s1_q [`DSCG_CHANNELS];
	dscg_pkg::sample_t s2_q [`DSCG_CHANNELS];
	logic [`DSCG_CHANNELS-1:0] busy_q;
	logic [SLOT_W-1:0] slots_q;
	logic is_step;
	logic head_busy;
	logic wb_hit;

	assign is_step = (cmd.op == dscg_pkg::STEP);
	assign head_busy = busy_q[cmd.chan];
	assign wb_hit = res_valid && (res.chan == cmd.chan);

	// every command waits while its channel is in flight, keeping strict order
	always_comb
	begin
		cmd_pop = 1'b0;
		if (!cmd_empty && !head_busy)
		begin
			if (is_step)
			begin
				cmd_pop = (slots_q != '0) && !wb_hit;
			end
			else
			begin
				cmd_pop = 1'b1;
			end
		end
	end

	assign issue_valid = cmd_pop && is_step;

	always_comb
	begin
		issue.chan = cmd.chan;
		issue.c = c_q[cmd.chan];
		issue.s1 = s1_q[cmd.chan];
		issue.s2 = s2_q[cmd.chan];
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < `DSCG_CHANNELS; i++)
			begin
				c_q[i] <= '0;
				s1_q[i] <= '0;
				s2_q[i] <= '0;
			end
			busy_q <= '0;
			slots_q <= SLOT_W'(`DSCG_OUT_DEPTH);
		end
		else
		begin
			// writeback from execute, never the same channel as a popped command
			if (res_valid)
			begin
				s1_q[res.chan] <= res.s1;
				s2_q[res.chan] <= res.s2;
				busy_q[res.chan] <= 1'b0;
			end
			if (cmd_pop)
			begin
				case (cmd.op)
					dscg_pkg::SET_COEF:
					begin
						c_q[cmd.chan] <= cmd.a;
					end
					dscg_pkg::SET_STATE:
					begin
						s1_q[cmd.chan] <= cmd.a;
						s2_q[cmd.chan] <= cmd.b;
					end
					dscg_pkg::STEP:
					begin
						busy_q[cmd.chan] <= 1'b1;
					end
					default:
					begin
					end
				endcase
			end
			// a result slot is reserved at issue and returned when result pops it
			slots_q <= slots_q - SLOT_W'(issue_valid) + SLOT_W'(slot_free);
		end
	end

endmodule

// File: logic/dscg_execute.sv
// dscg arithmetic pipeline with delay balancing of the direct products
`include "dscg_consts.svh"

module dscg_execute (
	input  logic                   clock,
	input  logic                   rst,
	input  dscg_pkg::issue_t       issue,
	input  logic                   issue_valid,
	output dscg_pkg::sample_pair_t res,
	output logic                   res_valid
);

	typedef dscg_pkg::sample_t [1:0] prod_pair_t;

	localparam dscg_pkg::sample_t ONE = dscg_pkg::sample_t'(1) << `DSCG_FRAC;

	dscg_pkg::sample_t add1_q;
	dscg_pkg::sample_t sub5_q;
	dscg_pkg::sample_t s1_q;
	dscg_pkg::sample_t s2_q;
	dscg_pkg::sample_t x2;
	dscg_pkg::sample_t x3;
	dscg_pkg::sample_t x6;
	dscg_pkg::sample_t x7;
	prod_pair_t direct_d;
	dscg_pkg::sample_t s1_sum_q;
	dscg_pkg::sample_t s2_sum_q;
	dscg_pkg::tag_t tag_in;
	dscg_pkg::tag_t tag_out;

	// first adder stage, c + 1 and 1 - c with the state held alongside
	always_ff @(posedge clock)
	begin
		add1_q <= issue.c + ONE;
		sub5_q <= ONE - issue.c;
		s1_q <= issue.s1;
		s2_q <= issue.s2;
	end

	// cross products start one cycle late, after the adder stage
	fxp_mul_pipe u_mul_x2 (.clock(clock), .a(add1_q), .b(s2_q), .p(x2));
	fxp_mul_pipe u_mul_x6 (.clock(clock), .a(sub5_q), .b(s1_q), .p(x6));

	// direct products start at issue, so they wait out the adder stage
	fxp_mul_pipe u_mul_x3 (.clock(clock), .a(issue.c), .b(issue.s1), .p(x3));
	fxp_mul_pipe u_mul_x7 (.clock(clock), .a(issue.c), .b(issue.s2), .p(x7));

	delay_line #(
		.T(prod_pair_t),
		.DEPTH(`DSCG_ADD_STAGES)
	) u_direct_dly (
		.clock(clock),
		.rst(rst),
		.in_data({x3, x7}),
		.out_data(direct_d)
	);

	always_ff @(posedge clock)
	begin
		s1_sum_q <= x2 + direct_d[1];
		s2_sum_q <= x6 + direct_d[0];
	end

	assign tag_in.valid = issue_valid;
	assign tag_in.chan = issue.chan;

	delay_line #(
		.T(dscg_pkg::tag_t),
		.DEPTH(`DSCG_LATENCY)
	) u_tag_dly (
		.clock(clock),
		.rst(rst),
		.in_data(tag_in),
		.out_data(tag_out)
	);

	assign res.chan = tag_out.chan;
	assign res.s1 = s1_sum_q;
	assign res.s2 = s2_sum_q;
	assign res_valid = tag_out.valid;

endmodule

// File: logic/dscg_result.sv
// result buffer that forwards samples to the consumer under credits
`include "dscg_consts.svh"

module dscg_result (
	input  logic                   clock,
	input  logic                   rst,
	input  dscg_pkg::sample_pair_t res,
	input  logic                   res_valid,
	input  logic                   out_credit,
	output dscg_pkg::sample_pair_t out_sample,
	output logic                   out_valid,
	output logic                   slot_free
);

	localparam int CRED_W = $clog2(`DSCG_OUT_CREDITS + 1);

	dscg_pkg::sample_pair_t head;
	logic empty;
	logic pop;
	logic [CRED_W-1:0] credits_q;

	credit_fifo #(
		.T(dscg_pkg::sample_pair_t),
		.DEPTH(`DSCG_OUT_DEPTH)
	) u_out_fifo (
		.clock(clock),
		.rst(rst),
		.push(res_valid),
		.push_data(res),
		.pop(pop),
		.pop_data(head),
		.empty(empty),
		.credit(slot_free)
	);

	// send only while the consumer has room
	assign pop = !empty && (credits_q != '0);

	always_ff @(posedge clock)
	begin
		out_sample <= head;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			credits_q <= CRED_W'(`DSCG_OUT_CREDITS);
		end
		else
		begin
			out_valid <= pop;
			credits_q <= credits_q - CRED_W'(pop) + CRED_W'(out_credit);
		end
	end

endmodule

// File: logic/dscg_osc_top.sv
// multi-channel dscg oscillator top level with credit-based command and sample ports
`include "dscg_consts.svh"

module dscg_osc_top (
	input  logic                   clock,
	input  logic                   rst,
	input  dscg_pkg::cmd_t         cmd,
	input  logic                   cmd_valid,
	input  logic                   out_credit,
	output logic                   cmd_credit,
	output dscg_pkg::sample_pair_t out_sample,
	output logic                   out_valid
);

	dscg_pkg::cmd_t head_cmd;
	logic cmd_empty;
	logic cmd_pop;
	dscg_pkg::issue_t issue;
	logic issue_valid;
	dscg_pkg::sample_pair_t res;
	logic res_valid;
	logic slot_free;

	// the pop credit goes straight back to the sender
	credit_fifo #(
		.T(dscg_pkg::cmd_t),
		.DEPTH(`DSCG_CMD_DEPTH)
	) u_cmd_fifo (
		.clock(clock),
		.rst(rst),
		.push(cmd_valid),
		.push_data(cmd),
		.pop(cmd_pop),
		.pop_data(head_cmd),
		.empty(cmd_empty),
		.credit(cmd_credit)
	);

	dscg_decode u_decode (
		.clock(clock),
		.rst(rst),
		.cmd(head_cmd),
		.cmd_empty(cmd_empty),
		.res(res),
		.res_valid(res_valid),
		.slot_free(slot_free),
		.cmd_pop(cmd_pop),
		.issue(issue),
		.issue_valid(issue_valid)
	);

	dscg_execute u_execute (
		.clock(clock),
		.rst(rst),
		.issue(issue),
		.issue_valid(issue_valid),
		.res(res),
		.res_valid(res_valid)
	);

	dscg_result u_result (
		.clock(clock),
		.rst(rst),
		.res(res),
		.res_valid(res_valid),
		.out_credit(out_credit),
		.out_sample(out_sample),
		.out_valid(out_valid),
		.slot_free(slot_free)
	);

endmodule

// File: tests/dscg_osc_tb.sv
// dscg oscillator testbench with a fixed-point model, credit-gated sender and consumer
`include "dscg_consts.svh"

module dscg_osc_tb;

	localparam int NUM_CMDS = 82;
	localparam int WATCHDOG_TIME = NUM_CMDS * (`DSCG_LATENCY + 10) * 4 + 1000;
	localparam dscg_pkg::sample_t FX_ONE = dscg_pkg::sample_t'(1) << `DSCG_FRAC;

	logic clock;
	logic rst;
	dscg_pkg::cmd_t cmd;
	logic cmd_valid;
	logic out_credit;
	logic cmd_credit;
	dscg_pkg::sample_pair_t out_sample;
	logic out_valid;

	// model state per channel kept in command order
	dscg_pkg::sample_t coef_model [`DSCG_CHANNELS];
	dscg_pkg::sample_t s1_model [`DSCG_CHANNELS];
	dscg_pkg::sample_t s2_model [`DSCG_CHANNELS];
	dscg_pkg::sample_pair_t expected_q [$];
	dscg_pkg::sample_pair_t got_q [$];
	int sender_credits;
	int owed_credits;
	bit hold_credits;
	int errors;
	int checks;
	int unsigned lcg_state;

	dscg_osc_top u_dscg_osc_top (
		.clock(clock),
		.rst(rst),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.out_credit(out_credit),
		.cmd_credit(cmd_credit),
		.out_sample(out_sample),
		.out_valid(out_valid)
	);

	always #2 clock = ~clock;

	initial
	begin
		#(WATCHDOG_TIME);
		$display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
		$display("Simulation failed");
		$finish;
	end

	// outputs are taken at the rising edge before the DUT registers update
	always @(posedge clock)
	begin
		if (!rst)
		begin
			if (cmd_credit)
			begin
				sender_credits++;
			end
			if (out_valid)
			begin
				got_q.push_back(out_sample);
				owed_credits++;
			end
		end
	end

	// consumer hands back one credit per cycle unless held
	always @(negedge clock)
	begin
		if (!hold_credits && owed_credits > 0)
		begin
			out_credit = 1'b1;
			owed_credits--;
		end
		else
		begin
			out_credit = 1'b0;
		end
	end

	function automatic dscg_pkg::sample_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return dscg_pkg::sample_t'($signed(lcg_state) >>> 1);
	endfunction

	// full signed product floored by the fraction width and cut to the low word
	function automatic dscg_pkg::sample_t fx_mul(input dscg_pkg::sample_t a,
		input dscg_pkg::sample_t b);
		longint prod;
		prod = longint'(a) * longint'(b);
		return dscg_pkg::sample_t'(prod >>> `DSCG_FRAC);
	endfunction

	task automatic check_pair(input string name, input dscg_pkg::sample_pair_t exp,
		input dscg_pkg::sample_pair_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s expected chan %0d s1 %h s2 %h actual chan %0d s1 %h s2 %h",
				name, exp.chan, exp.s1, exp.s2, act.chan, act.s1, act.s2);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	// caller sits on a falling edge and sends one command per cycle while credits last
	task automatic send_cmd(input dscg_pkg::cmd_t c);
		while (sender_credits == 0)
		begin
			@(negedge clock);
		end
		cmd = c;
		cmd_valid = 1'b1;
		sender_credits--;
		@(negedge clock);
		cmd_valid = 1'b0;
	endtask

	task automatic set_coef(input int ch, input dscg_pkg::sample_t c);
		dscg_pkg::cmd_t cm;
		cm.op = dscg_pkg::SET_COEF;
		cm.chan = dscg_pkg::chan_t'(ch);
		cm.a = c;
		cm.b = '0;
		coef_model[ch] = c;
		send_cmd(cm);
	endtask

	task automatic set_state(input int ch, input dscg_pkg::sample_t s1,
		input dscg_pkg::sample_t s2);
		dscg_pkg::cmd_t cm;
		cm.op = dscg_pkg::SET_STATE;
		cm.chan = dscg_pkg::chan_t'(ch);
		cm.a = s1;
		cm.b = s2;
		s1_model[ch] = s1;
		s2_model[ch] = s2;
		send_cmd(cm);
	endtask

	// new s1 = (c+1)s2 + c s1, new s2 = (1-c)s1 + c s2
	task automatic step(input int ch);
		dscg_pkg::cmd_t cm;
		dscg_pkg::sample_pair_t exp;
		dscg_pkg::sample_t c_plus;
		dscg_pkg::sample_t c_minus;
		c_plus = coef_model[ch] + FX_ONE;
		c_minus = FX_ONE - coef_model[ch];
		exp.chan = dscg_pkg::chan_t'(ch);
		exp.s1 = fx_mul(c_plus, s2_model[ch]) + fx_mul(coef_model[ch], s1_model[ch]);
		exp.s2 = fx_mul(c_minus, s1_model[ch]) + fx_mul(coef_model[ch], s2_model[ch]);
		s1_model[ch] = exp.s1;
		s2_model[ch] = exp.s2;
		expected_q.push_back(exp);
		cm.op = dscg_pkg::STEP;
		cm.chan = dscg_pkg::chan_t'(ch);
		cm.a = '0;
		cm.b = '0;
		send_cmd(cm);
	endtask

	task automatic load_random(input int ch);
		dscg_pkg::sample_t c;
		dscg_pkg::sample_t s1;
		dscg_pkg::sample_t s2;
		c = lcg_next();
		s1 = lcg_next();
		s2 = lcg_next();
		set_coef(ch, c);
		set_state(ch, s1, s2);
	endtask

	// waits for every predicted sample and then compares them in order
	task automatic check_samples(input string name);
		int waited;
		waited = 0;
		while (got_q.size() < expected_q.size() && waited < 500)
		begin
			@(posedge clock);
			waited++;
		end
		if (got_q.size() < expected_q.size())
		begin
			errors++;
			$display("%s: only %0d of %0d samples arrived", name, got_q.size(),
				expected_q.size());
		end
		while (got_q.size() > 0 && expected_q.size() > 0)
		begin
			check_pair(name, expected_q.pop_front(), got_q.pop_front());
		end
		expected_q.delete();
		@(negedge clock);
	endtask

	task automatic reset_idle();
		repeat (10)
		begin
			@(posedge clock);
			if (cmd_credit || out_valid)
			begin
				errors++;
				$display("reset_idle: cmd_credit or out_valid went high with no traffic");
			end
		end
		@(negedge clock);
		load_random(0);
		step(0);
		check_samples("reset_idle");
	endtask

	task automatic single_channel_run();
		// c is cos(2*pi/16) and both states start at one half
		set_coef(1, 32'sd992008094);
		set_state(1, 32'sd536870912, 32'sd536870912);
		repeat (20)
		begin
			step(1);
		end
		check_samples("single_channel_run");
	endtask

	task automatic interleaved_channels();
		for (int ch = 0; ch < `DSCG_CHANNELS; ch++)
		begin
			load_random(ch);
		end
		repeat (8)
		begin
			for (int ch = 0; ch < `DSCG_CHANNELS; ch++)
			begin
				step(ch);
			end
		end
		check_samples("interleaved_channels");
	endtask

	task automatic output_backpressure();
		int waited;
		while (owed_credits != 0)
		begin
			@(negedge clock);
		end
		@(posedge clock);
		hold_credits = 1'b1;
		@(negedge clock);
		for (int i = 0; i < 8; i++)
		begin
			step(i % `DSCG_CHANNELS);
		end
		repeat (40)
		begin
			@(posedge clock);
		end
		check_count("output_backpressure", `DSCG_OUT_CREDITS, got_q.size());
		@(posedge clock);
		hold_credits = 1'b0;
		@(negedge clock);
		check_samples("output_backpressure");
		waited = 0;
		while (sender_credits != `DSCG_CMD_DEPTH && waited < 100)
		begin
			@(negedge clock);
			waited++;
		end
		check_count("output_backpressure", `DSCG_CMD_DEPTH, sender_credits);
	endtask

	task automatic state_reload();
		dscg_pkg::sample_t s1;
		dscg_pkg::sample_t s2;
		dscg_pkg::sample_t c;
		load_random(3);
		step(3);
		step(3);
		// reload lands while channel 3 is still in flight
		s1 = lcg_next();
		s2 = lcg_next();
		set_state(3, s1, s2);
		step(3);
		c = lcg_next();
		set_coef(3, c);
		step(3);
		step(3);
		check_samples("state_reload");
	endtask

	initial
	begin
		clock = 1'b0;
		rst = 1'b1;
		cmd = '0;
		cmd_valid = 1'b0;
		out_credit = 1'b0;
		hold_credits = 1'b0;
		sender_credits = `DSCG_CMD_DEPTH;
		owed_credits = 0;
		errors = 0;
		checks = 0;
		lcg_state = 23;
		for (int i = 0; i < `DSCG_CHANNELS; i++)
		begin
			coef_model[i] = '0;
			s1_model[i] = '0;
			s2_model[i] = '0;
		end
		repeat (5)
		begin
			@(posedge clock);
		end
		@(negedge clock);
		rst = 1'b0;
		reset_idle();
		single_channel_run();
		interleaved_channels();
		output_backpressure();
		state_reload();
		repeat (20)
		begin
			@(posedge clock);
		end
		check_count("final_drain", 0, got_q.size());
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Simulation completed successfully");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: dscg_osc.f
+incdir+logic
logic/dscg_pkg.sv
logic/credit_fifo.sv
logic/delay_line.sv
logic/fxp_mul_pipe.sv
logic/dscg_decode.sv
logic/dscg_execute.sv
logic/dscg_result.sv
logic/dscg_osc_top.sv
tests/dscg_osc_tb.sv

// File: Bender.yml
package:
  name: dscg_osc

export_include_dirs:
  - logic

sources:
  - logic/dscg_pkg.sv
  - logic/credit_fifo.sv
  - logic/delay_line.sv
  - logic/fxp_mul_pipe.sv
  - logic/dscg_decode.sv
  - logic/dscg_execute.sv
  - logic/dscg_result.sv
  - logic/dscg_osc_top.sv
  - target: test
    files:
      - tests/dscg_osc_tb.sv
